// File: common/soc_pkg.sv
package soc_pkg;

  // ------------------------------
  // Bus widths and types
  // ------------------------------
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned WordOffBits = $clog2(StrbWidth);

  typedef logic [DataWidth-1:0] word_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam int unsigned NumSramBanks     = 2;
  localparam int unsigned SramBankWords    = 256;
  localparam int unsigned SramBankIdxWidth = $clog2(SramBankWords);
  localparam int unsigned SramBankBytes    = SramBankWords * StrbWidth;
  localparam word_t       SramBaseAddr     = 32'h1000_0000;

  // Peripherals each own a 4 KiB window
  localparam int unsigned PeriphWinBits = 12;
  localparam word_t       SocCtrlBase   = 32'h0300_0000;
  localparam word_t       GpioBase      = 32'h0300_5000;
  localparam word_t       TimerBase     = 32'h0300_A000;

  typedef enum logic [2:0] {
    Bank0,
    Bank1,
    SocCtrl,
    Gpio,
    Timer,
    Error
  } target_e;

  // Error is not a real target
  localparam int unsigned NumTargets = 5;
  localparam word_t       ErrRspData = 32'hBADC_AB1E;

  // Register offsets within a peripheral window
  localparam logic [PeriphWinBits-1:0] BootAddrOff  = 12'h000;
  localparam logic [PeriphWinBits-1:0] FetchEnOff   = 12'h004;

  localparam logic [PeriphWinBits-1:0] DirOff       = 12'h000;
  localparam logic [PeriphWinBits-1:0] OutOff       = 12'h004;
  localparam logic [PeriphWinBits-1:0] InOff        = 12'h008;
  localparam logic [PeriphWinBits-1:0] IrqEnOff     = 12'h00C;
  localparam logic [PeriphWinBits-1:0] IrqStatusOff = 12'h010;

  localparam logic [PeriphWinBits-1:0] CtrlOff      = 12'h000;
  localparam logic [PeriphWinBits-1:0] CountOff     = 12'h004;
  localparam logic [PeriphWinBits-1:0] CompareOff   = 12'h008;

  localparam int unsigned NumGpios = 16;

  // Interrupt vector layout
  localparam int unsigned NumExtIrqs = 4;
  localparam int unsigned IrqTimer   = 0;
  localparam int unsigned IrqGpio    = 1;
  localparam int unsigned IrqExtLsb  = 2;
  localparam int unsigned NumIrqs    = 6;

  // Expands byte enables to a bit mask
  function automatic word_t be_to_mask(strb_t be);
    word_t mask;
    for (int i = 0; i < StrbWidth; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

endpackage

// File: design/bus_demux.sv
`timescale 1ns/1ps

module bus_demux (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  logic                                       bus_req_i,
  input  logic                                       bus_we_i,
  input  soc_pkg::word_t                             bus_addr_i,
  input  soc_pkg::word_t                             bus_wdata_i,
  input  soc_pkg::strb_t                             bus_be_i,
  input  soc_pkg::word_t [soc_pkg::NumTargets-1:0]   tgt_rdata_i,
  output logic                                       bus_rvalid_o,
  output soc_pkg::word_t                             bus_rdata_o,
  output logic                                       bus_err_o,
  output logic [soc_pkg::NumTargets-1:0]             tgt_req_o,
  output logic                                       tgt_we_o,
  output soc_pkg::word_t                             tgt_addr_o,
  output soc_pkg::word_t                             tgt_wdata_o,
  output soc_pkg::strb_t                             tgt_be_o
);

  soc_pkg::target_e tgt_sel;
  soc_pkg::target_e rsp_tgt_q;
  logic             rsp_valid_q;
  logic             rsp_we_q;

  function automatic logic in_window(logic [soc_pkg::AddrWidth-1:0] addr,
                                     logic [soc_pkg::AddrWidth-1:0] base,
                                     int unsigned                   win_bits);
    return (addr >> win_bits) == (base >> win_bits);
  endfunction

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb begin
    tgt_sel = soc_pkg::Error;
    for (int b = 0; b < soc_pkg::NumSramBanks; b++) begin
      if (in_window(bus_addr_i, soc_pkg::SramBaseAddr + b * soc_pkg::SramBankBytes,
                    soc_pkg::SramBankIdxWidth + soc_pkg::WordOffBits)) begin
        tgt_sel = soc_pkg::target_e'(int'(soc_pkg::Bank0) + b);
      end
    end
    if (in_window(bus_addr_i, soc_pkg::SocCtrlBase, soc_pkg::PeriphWinBits)) begin
      tgt_sel = soc_pkg::SocCtrl;
    end
    if (in_window(bus_addr_i, soc_pkg::GpioBase, soc_pkg::PeriphWinBits)) begin
      tgt_sel = soc_pkg::Gpio;
    end
    if (in_window(bus_addr_i, soc_pkg::TimerBase, soc_pkg::PeriphWinBits)) begin
      tgt_sel = soc_pkg::Timer;
    end
  end

  // Strobe goes to one target, none when unmapped
  always_comb begin
    tgt_req_o = '0;
    if (bus_req_i && tgt_sel != soc_pkg::Error) begin
      tgt_req_o[tgt_sel] = 1'b1;
    end
  end

  assign tgt_we_o    = bus_we_i;
  assign tgt_addr_o  = bus_addr_i;
  assign tgt_wdata_o = bus_wdata_i;
  assign tgt_be_o    = bus_be_i;

  // ------------------------------
  // Response path
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_we_q    <= 1'b0;
      rsp_tgt_q   <= soc_pkg::Error;
    end else begin
      rsp_valid_q <= bus_req_i;
      if (bus_req_i) begin
        rsp_we_q  <= bus_we_i;
        rsp_tgt_q <= tgt_sel;
      end
    end
  end

  // Writes answer with zero data
  always_comb begin
    bus_rdata_o = '0;
    if (rsp_valid_q) begin
      if (rsp_tgt_q == soc_pkg::Error) begin
        bus_rdata_o = soc_pkg::ErrRspData;
      end else if (!rsp_we_q) begin
        bus_rdata_o = tgt_rdata_i[rsp_tgt_q];
      end
    end
  end

  assign bus_rvalid_o = rsp_valid_q;
  assign bus_err_o    = rsp_valid_q && (rsp_tgt_q == soc_pkg::Error);

endmodule

// File: design/sram_bank.sv
`timescale 1ns/1ps

module sram_bank (
  input  logic           clk_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::word_t addr_i,
  input  soc_pkg::word_t wdata_i,
  input  soc_pkg::strb_t be_i,
  output soc_pkg::word_t rdata_o
);

  soc_pkg::word_t                       mem_q [soc_pkg::SramBankWords];
  logic [soc_pkg::SramBankIdxWidth-1:0] word_idx;
  soc_pkg::word_t                       wmask;

  // Word index sits above the byte offset
  assign word_idx = addr_i[soc_pkg::WordOffBits +: soc_pkg::SramBankIdxWidth];
  assign wmask    = soc_pkg::be_to_mask(be_i);

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[word_idx] <= (mem_q[word_idx] & ~wmask) | (wdata_i & wmask);
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

endmodule

// File: design/soc_ctrl_regs.sv
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::word_t addr_i,
  input  soc_pkg::word_t wdata_i,
  input  soc_pkg::strb_t be_i,
  input  logic           fetch_en_i,
  output soc_pkg::word_t rdata_o,
  output soc_pkg::word_t boot_addr_o,
  output logic           fetch_enable_o
);

  logic [soc_pkg::PeriphWinBits-1:0] reg_off;
  soc_pkg::word_t                    wmask;
  soc_pkg::word_t                    boot_addr_q;
  logic                              fetch_en_q;

  assign reg_off = addr_i[soc_pkg::PeriphWinBits-1:0];
  assign wmask   = soc_pkg::be_to_mask(be_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= soc_pkg::SramBaseAddr;
      fetch_en_q  <= 1'b0;
    end else if (req_i && we_i) begin
      case (reg_off)
        soc_pkg::BootAddrOff: boot_addr_q <= (boot_addr_q & ~wmask) | (wdata_i & wmask);
        soc_pkg::FetchEnOff: begin
          if (be_i[0]) begin
            fetch_en_q <= wdata_i[0];
          end
        end
        default: ;
      endcase
    end
  end

  // Read back, unknown offsets give zero
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (reg_off)
        soc_pkg::BootAddrOff: rdata_o <= boot_addr_q;
        soc_pkg::FetchEnOff:  rdata_o <= soc_pkg::word_t'(fetch_en_q);
        default:              rdata_o <= '0;
      endcase
    end
  end

  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

// File: gpio/gpio.sv
`timescale 1ns/1ps

module gpio #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  soc_pkg::word_t       addr_i,
  input  soc_pkg::word_t       wdata_i,
  input  soc_pkg::strb_t       be_i,
  input  logic [GpioCount-1:0] gpio_i,
  output soc_pkg::word_t       rdata_o,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic                 irq_o
);

  logic [soc_pkg::PeriphWinBits-1:0] reg_off;
  logic                              wr_en;
  soc_pkg::word_t                    wmask;
  soc_pkg::word_t                    wbits;

  logic [GpioCount-1:0] dir_q;
  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] irq_en_q;
  logic [GpioCount-1:0] status_q;
  logic [GpioCount-1:0] sync_q1;
  logic [GpioCount-1:0] sync_q2;
  logic [GpioCount-1:0] prev_q;
  logic [GpioCount-1:0] rise_en;
  logic [GpioCount-1:0] status_clr;
  logic [GpioCount-1:0] keep_mask;

  assign reg_off   = addr_i[soc_pkg::PeriphWinBits-1:0];
  assign wr_en     = req_i && we_i;
  assign wmask     = soc_pkg::be_to_mask(be_i);
  assign wbits     = wdata_i & wmask;
  assign keep_mask = ~wmask[GpioCount-1:0];

  // Rising edges on enabled pins only
  assign rise_en    = sync_q2 & ~prev_q & irq_en_q;
  assign status_clr = (wr_en && reg_off == soc_pkg::IrqStatusOff) ? wbits[GpioCount-1:0] : '0;

  // ------------------------------
  // Input synchronizer
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
    end else begin
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | rise_en;
      if (wr_en) begin
        case (reg_off)
          soc_pkg::DirOff:   dir_q    <= (dir_q & keep_mask) | wbits[GpioCount-1:0];
          soc_pkg::OutOff:   out_q    <= (out_q & keep_mask) | wbits[GpioCount-1:0];
          soc_pkg::IrqEnOff: irq_en_q <= (irq_en_q & keep_mask) | wbits[GpioCount-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (reg_off)
        soc_pkg::DirOff:       rdata_o <= soc_pkg::word_t'(dir_q);
        soc_pkg::OutOff:       rdata_o <= soc_pkg::word_t'(out_q);
        soc_pkg::InOff:        rdata_o <= soc_pkg::word_t'(sync_q2);
        soc_pkg::IrqEnOff:     rdata_o <= soc_pkg::word_t'(irq_en_q);
        soc_pkg::IrqStatusOff: rdata_o <= soc_pkg::word_t'(status_q);
        default:               rdata_o <= '0;
      endcase
    end
  end

  assign gpio_o        = out_q;
  assign gpio_out_en_o = dir_q;
  assign irq_o         = |status_q;

endmodule

// File: timer/timer.sv
`timescale 1ns/1ps

module timer (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::word_t addr_i,
  input  soc_pkg::word_t wdata_i,
  input  soc_pkg::strb_t be_i,
  output soc_pkg::word_t rdata_o,
  output logic           irq_o
);

  logic [soc_pkg::PeriphWinBits-1:0] reg_off;
  soc_pkg::word_t                    wmask;
  soc_pkg::word_t                    count_q;
  soc_pkg::word_t                    cmp_q;
  logic                              en_q;
  logic                              irq_q;

  assign reg_off = addr_i[soc_pkg::PeriphWinBits-1:0];
  assign wmask   = soc_pkg::be_to_mask(be_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
      irq_q   <= 1'b0;
    end else begin
      irq_q <= 1'b0;
      // Wrap one cycle after the match, period is Compare+1
      if (en_q) begin
        if (count_q == cmp_q) begin
          count_q <= '0;
          irq_q   <= 1'b1;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
      // Bus write overrides the count update
      if (req_i && we_i) begin
        case (reg_off)
          soc_pkg::CtrlOff: begin
            if (be_i[0]) begin
              en_q <= wdata_i[0];
            end
          end
          soc_pkg::CountOff:   count_q <= (count_q & ~wmask) | (wdata_i & wmask);
          soc_pkg::CompareOff: cmp_q   <= (cmp_q & ~wmask) | (wdata_i & wmask);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (reg_off)
        soc_pkg::CtrlOff:    rdata_o <= soc_pkg::word_t'(en_q);
        soc_pkg::CountOff:   rdata_o <= count_q;
        soc_pkg::CompareOff: rdata_o <= cmp_q;
        default:             rdata_o <= '0;
      endcase
    end
  end

  assign irq_o = irq_q;

endmodule

// File: design/soc_domain.sv
`timescale 1ns/1ps

module soc_domain (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            fetch_en_i,
  input  logic                            bus_req_i,
  input  logic                            bus_we_i,
  input  soc_pkg::word_t                  bus_addr_i,
  input  soc_pkg::word_t                  bus_wdata_i,
  input  soc_pkg::strb_t                  bus_be_i,
  input  logic [soc_pkg::NumGpios-1:0]    gpio_i,
  input  logic [soc_pkg::NumExtIrqs-1:0]  ext_irq_i,
  output logic                            bus_rvalid_o,
  output soc_pkg::word_t                  bus_rdata_o,
  output logic                            bus_err_o,
  output logic [soc_pkg::NumGpios-1:0]    gpio_o,
  output logic [soc_pkg::NumGpios-1:0]    gpio_out_en_o,
  output soc_pkg::word_t                  boot_addr_o,
  output logic                            fetch_enable_o,
  output logic [soc_pkg::NumIrqs-1:0]     irq_o
);

  logic [soc_pkg::NumTargets-1:0]           tgt_req;
  logic                                     tgt_we;
  soc_pkg::word_t                           tgt_addr;
  soc_pkg::word_t                           tgt_wdata;
  soc_pkg::strb_t                           tgt_be;
  soc_pkg::word_t [soc_pkg::NumTargets-1:0] tgt_rdata;

  logic timer_irq;
  logic gpio_irq;

  // Interrupt vector
  always_comb begin
    irq_o                                         = '0;
    irq_o[soc_pkg::IrqTimer]                      = timer_irq;
    irq_o[soc_pkg::IrqGpio]                       = gpio_irq;
    irq_o[soc_pkg::IrqExtLsb +: soc_pkg::NumExtIrqs] = ext_irq_i;
  end

  // ------------------------------
  // Interconnect
  // ------------------------------
  bus_demux i_bus_demux (
    .clk_i,
    .arst_n_i,
    .bus_req_i,
    .bus_we_i,
    .bus_addr_i,
    .bus_wdata_i,
    .bus_be_i,
    .tgt_rdata_i  ( tgt_rdata ),
    .bus_rvalid_o,
    .bus_rdata_o,
    .bus_err_o,
    .tgt_req_o    ( tgt_req   ),
    .tgt_we_o     ( tgt_we    ),
    .tgt_addr_o   ( tgt_addr  ),
    .tgt_wdata_o  ( tgt_wdata ),
    .tgt_be_o     ( tgt_be    )
  );

  // ------------------------------
  // Memories and peripherals
  // ------------------------------
  for (genvar i = 0; i < soc_pkg::NumSramBanks; i++) begin : gen_sram_bank
    sram_bank i_sram_bank (
      .clk_i,
      .req_i   ( tgt_req[soc_pkg::Bank0 + i]   ),
      .we_i    ( tgt_we                        ),
      .addr_i  ( tgt_addr                      ),
      .wdata_i ( tgt_wdata                     ),
      .be_i    ( tgt_be                        ),
      .rdata_o ( tgt_rdata[soc_pkg::Bank0 + i] )
    );
  end

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .arst_n_i,
    .req_i          ( tgt_req[soc_pkg::SocCtrl]   ),
    .we_i           ( tgt_we                      ),
    .addr_i         ( tgt_addr                    ),
    .wdata_i        ( tgt_wdata                   ),
    .be_i           ( tgt_be                      ),
    .fetch_en_i,
    .rdata_o        ( tgt_rdata[soc_pkg::SocCtrl] ),
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio #(
    .GpioCount ( soc_pkg::NumGpios )
  ) i_gpio (
    .clk_i,
    .arst_n_i,
    .req_i         ( tgt_req[soc_pkg::Gpio]   ),
    .we_i          ( tgt_we                   ),
    .addr_i        ( tgt_addr                 ),
    .wdata_i       ( tgt_wdata                ),
    .be_i          ( tgt_be                   ),
    .gpio_i,
    .rdata_o       ( tgt_rdata[soc_pkg::Gpio] ),
    .gpio_o,
    .gpio_out_en_o,
    .irq_o         ( gpio_irq                 )
  );

  timer i_timer (
    .clk_i,
    .arst_n_i,
    .req_i   ( tgt_req[soc_pkg::Timer]   ),
    .we_i    ( tgt_we                    ),
    .addr_i  ( tgt_addr                  ),
    .wdata_i ( tgt_wdata                 ),
    .be_i    ( tgt_be                    ),
    .rdata_o ( tgt_rdata[soc_pkg::Timer] ),
    .irq_o   ( timer_irq                 )
  );

endmodule

// File: verification/tb_soc_domain.sv
`timescale 1ns/1ps

module tb_soc_domain;

  localparam time ClkPeriod = 8ns;
  localparam int  ModelWords = soc_pkg::NumSramBanks * soc_pkg::SramBankWords;

  // Cycle budget of each test for the watchdog
  localparam int ResetCycles = 10;
  localparam int SramCycles  = 200;
  localparam int ErrCycles   = 20;
  localparam int CtrlCycles  = 30;
  localparam int GpioCycles  = 60;
  localparam int TimerCycles = 80;
  localparam int IrqCycles   = 20;
  localparam int TestCycles  = ResetCycles + SramCycles + ErrCycles + CtrlCycles
                             + GpioCycles + TimerCycles + IrqCycles;

  logic                               clk_i = 1'b0;
  logic                               arst_n_i;
  logic                               fetch_en_i;
  logic                               bus_req_i;
  logic                               bus_we_i;
  soc_pkg::word_t                     bus_addr_i;
  soc_pkg::word_t                     bus_wdata_i;
  soc_pkg::strb_t                     bus_be_i;
  logic [soc_pkg::NumGpios-1:0]       gpio_i;
  logic [soc_pkg::NumExtIrqs-1:0]     ext_irq_i;
  logic                               bus_rvalid_o;
  soc_pkg::word_t                     bus_rdata_o;
  logic                               bus_err_o;
  logic [soc_pkg::NumGpios-1:0]       gpio_o;
  logic [soc_pkg::NumGpios-1:0]       gpio_out_en_o;
  soc_pkg::word_t                     boot_addr_o;
  logic                               fetch_enable_o;
  logic [soc_pkg::NumIrqs-1:0]        irq_o;

  // Expected response driven along with each strobe
  soc_pkg::word_t exp_data;
  logic           exp_err;

  logic [15:0]    lfsr_q = 16'd11939;
  soc_pkg::word_t sram_model [ModelWords];
  logic           sram_valid [ModelWords];

  soc_domain DUT (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic fail_now(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // ------------------------------
  // Assertions
  // ------------------------------
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   bus_rvalid_o == $past(bus_req_i))
    else fail_now("bus_rvalid_o does not follow bus_req_i by one cycle");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   $past(bus_req_i) |-> (bus_rdata_o == $past(exp_data)
                                         && bus_err_o == $past(exp_err)))
    else fail_now($sformatf("response data %h err %b, expected %h err %b",
                            bus_rdata_o, bus_err_o, $past(exp_data), $past(exp_err)));

  assert property (@(posedge clk_i)
                   irq_o[soc_pkg::IrqExtLsb +: soc_pkg::NumExtIrqs] == ext_irq_i)
    else fail_now("external interrupt bits of irq_o differ from ext_irq_i");

  task automatic check_eq(input soc_pkg::word_t got, input soc_pkg::word_t exp,
                          input string what);
    assert (got == exp)
      else fail_now($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic soc_pkg::word_t rand_bits(input int n);
    soc_pkg::word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // One strobe with its expected response a cycle later
  task automatic bus_op(input logic we, input soc_pkg::word_t addr,
                        input soc_pkg::word_t wdata, input soc_pkg::strb_t be,
                        input soc_pkg::word_t rsp_data, input logic rsp_err);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_wdata_i = wdata;
    bus_be_i    = be;
    exp_data    = rsp_data;
    exp_err     = rsp_err;
    @(posedge clk_i);
    #1ns;
    bus_req_i = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1ns;
    end
  endtask

  function automatic soc_pkg::word_t sram_addr(input int idx);
    return soc_pkg::SramBaseAddr + idx * 4;
  endfunction

  // Model keeps only the enabled bytes
  task automatic sram_write(input int idx, input soc_pkg::word_t data, input soc_pkg::strb_t be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        sram_model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    bus_op(1'b1, sram_addr(idx), data, be, '0, 1'b0);
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin
    #(TestCycles * 2 * ClkPeriod);
    $display("Watchdog expired, the test did not finish in time");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  initial begin
    int             idx;
    int             cyc;
    int             pin;
    int             other;
    int             cmp;
    soc_pkg::word_t val;
    soc_pkg::word_t dir;
    soc_pkg::word_t outv;
    soc_pkg::word_t err_addr [4];

    arst_n_i    = 1'b0;
    fetch_en_i  = 1'b0;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    bus_be_i    = '0;
    gpio_i      = '0;
    ext_irq_i   = '0;
    exp_data    = '0;
    exp_err     = 1'b0;
    for (int i = 0; i < ModelWords; i++) begin
      sram_valid[i] = 1'b0;
      sram_model[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1ns;
    arst_n_i = 1'b1;

    // Outputs right after reset
    check_eq(soc_pkg::word_t'(bus_rvalid_o), '0, "bus_rvalid_o after reset");
    check_eq(soc_pkg::word_t'(gpio_out_en_o), '0, "gpio_out_en_o after reset");
    check_eq(soc_pkg::word_t'(irq_o), '0, "irq_o after reset");

    // Back-to-back SRAM writes to both banks
    for (int i = 0; i < 32; i++) begin
      idx = int'(rand_bits(9));
      if (!sram_valid[idx]) begin
        sram_write(idx, rand_bits(32), 4'hF);
        sram_valid[idx] = 1'b1;
      end
      sram_write(idx, rand_bits(32), soc_pkg::strb_t'(rand_bits(4)));
    end
    for (int i = 0; i < ModelWords; i++) begin
      if (sram_valid[i]) begin
        bus_op(1'b0, sram_addr(i), '0, 4'hF, sram_model[i], 1'b0);
      end
    end

    // Unmapped space answers with the error word
    err_addr[0] = 32'h0000_0000;
    err_addr[1] = 32'h2000_0000;
    err_addr[2] = soc_pkg::SramBaseAddr + 32'h800;
    err_addr[3] = soc_pkg::SocCtrlBase + 32'h1000;
    for (int i = 0; i < 4; i++) begin
      bus_op(1'b1, err_addr[i], rand_bits(32), 4'hF, soc_pkg::ErrRspData, 1'b1);
      bus_op(1'b0, err_addr[i], '0, 4'hF, soc_pkg::ErrRspData, 1'b1);
    end
    for (int i = 0; i < ModelWords; i++) begin
      if (sram_valid[i]) begin
        bus_op(1'b0, sram_addr(i), '0, 4'hF, sram_model[i], 1'b0);
      end
    end

    // ------------------------------
    // SoC control
    // ------------------------------
    bus_op(1'b0, soc_pkg::SocCtrlBase + soc_pkg::BootAddrOff, '0, 4'hF,
           soc_pkg::SramBaseAddr, 1'b0);
    check_eq(boot_addr_o, soc_pkg::SramBaseAddr, "boot_addr_o after reset");
    val = rand_bits(32);
    bus_op(1'b1, soc_pkg::SocCtrlBase + soc_pkg::BootAddrOff, val, 4'hF, '0, 1'b0);
    bus_op(1'b0, soc_pkg::SocCtrlBase + soc_pkg::BootAddrOff, '0, 4'hF, val, 1'b0);
    check_eq(boot_addr_o, val, "boot_addr_o after write");
    for (int r = 0; r < 2; r++) begin
      bus_op(1'b1, soc_pkg::SocCtrlBase + soc_pkg::FetchEnOff, r, 4'hF, '0, 1'b0);
      for (int p = 0; p < 2; p++) begin
        fetch_en_i = p[0];
        idle(1);
        check_eq(soc_pkg::word_t'(fetch_enable_o), soc_pkg::word_t'(r[0] | p[0]),
                 "fetch_enable_o");
      end
    end

    // ------------------------------
    // GPIO
    // ------------------------------
    dir  = rand_bits(16);
    outv = rand_bits(16);
    bus_op(1'b1, soc_pkg::GpioBase + soc_pkg::DirOff, dir, 4'hF, '0, 1'b0);
    bus_op(1'b1, soc_pkg::GpioBase + soc_pkg::OutOff, outv, 4'hF, '0, 1'b0);
    check_eq(soc_pkg::word_t'(gpio_out_en_o), dir, "gpio_out_en_o");
    check_eq(soc_pkg::word_t'(gpio_o), outv, "gpio_o");
    val    = rand_bits(16);
    gpio_i = val[15:0];
    idle(4);
    bus_op(1'b0, soc_pkg::GpioBase + soc_pkg::InOff, '0, 4'hF, val, 1'b0);
    gpio_i = '0;
    pin    = int'(rand_bits(4));
    other  = (pin + 5) % soc_pkg::NumGpios;
    bus_op(1'b1, soc_pkg::GpioBase + soc_pkg::IrqEnOff, 32'h1 << pin, 4'hF, '0, 1'b0);
    idle(4);
    bus_op(1'b0, soc_pkg::GpioBase + soc_pkg::IrqStatusOff, '0, 4'hF, '0, 1'b0);
    gpio_i[pin] = 1'b1;
    idle(4);
    bus_op(1'b0, soc_pkg::GpioBase + soc_pkg::IrqStatusOff, '0, 4'hF, 32'h1 << pin, 1'b0);
    check_eq(soc_pkg::word_t'(irq_o[soc_pkg::IrqGpio]), 32'h1, "GPIO interrupt after edge");
    // Edge on a pin without interrupt enable
    gpio_i[other] = 1'b1;
    idle(4);
    bus_op(1'b0, soc_pkg::GpioBase + soc_pkg::IrqStatusOff, '0, 4'hF, 32'h1 << pin, 1'b0);
    bus_op(1'b1, soc_pkg::GpioBase + soc_pkg::IrqStatusOff, 32'h1 << pin, 4'hF, '0, 1'b0);
    bus_op(1'b0, soc_pkg::GpioBase + soc_pkg::IrqStatusOff, '0, 4'hF, '0, 1'b0);
    check_eq(soc_pkg::word_t'(irq_o[soc_pkg::IrqGpio]), '0, "GPIO interrupt after clear");

    // ------------------------------
    // Timer
    // ------------------------------
    val = rand_bits(32);
    bus_op(1'b1, soc_pkg::TimerBase + soc_pkg::CountOff, val, 4'hF, '0, 1'b0);
    bus_op(1'b0, soc_pkg::TimerBase + soc_pkg::CountOff, '0, 4'hF, val, 1'b0);
    bus_op(1'b1, soc_pkg::TimerBase + soc_pkg::CountOff, '0, 4'hF, '0, 1'b0);
    cmp = 2 + int'(rand_bits(3));
    bus_op(1'b1, soc_pkg::TimerBase + soc_pkg::CompareOff, cmp, 4'hF, '0, 1'b0);
    bus_op(1'b1, soc_pkg::TimerBase + soc_pkg::CtrlOff, 32'h1, 4'hF, '0, 1'b0);
    cyc = 0;
    while (!irq_o[soc_pkg::IrqTimer] && cyc < 20) begin
      idle(1);
      cyc++;
    end
    assert (irq_o[soc_pkg::IrqTimer])
      else fail_now("no timer interrupt after enabling the timer");
    for (int p = 0; p < 3; p++) begin
      cyc = 0;
      do begin
        idle(1);
        cyc++;
        if (cyc == 1) begin
          check_eq(soc_pkg::word_t'(irq_o[soc_pkg::IrqTimer]), '0, "timer pulse width");
        end
      end while (!irq_o[soc_pkg::IrqTimer] && cyc < 20);
      check_eq(cyc, cmp + 1, "timer interrupt period in cycles");
    end
    bus_op(1'b1, soc_pkg::TimerBase + soc_pkg::CtrlOff, '0, 4'hF, '0, 1'b0);

    // External interrupt lines
    for (int i = 0; i < 8; i++) begin
      ext_irq_i = soc_pkg::NumExtIrqs'(rand_bits(soc_pkg::NumExtIrqs));
      idle(1);
    end
    idle(2);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: filelist.f
common/soc_pkg.sv
design/bus_demux.sv
design/sram_bank.sv
design/soc_ctrl_regs.sv
gpio/gpio.sv
timer/timer.sv
design/soc_domain.sv
verification/tb_soc_domain.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_domain -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/Vtb_soc_domain 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
